// ==== common/eth_pkg.sv ====
`default_nettype none

package eth_pkg;

  // Byte 5 is the first on the wire
  typedef logic [5:0][7:0] mac_addr_t;

  // Byte 3 is the first on the wire
  typedef logic [3:0][7:0] ipv4_t;

  typedef struct packed {
    mac_addr_t mac_addr;
    ipv4_t     ipv4_addr;
  } dev_t;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800; // Protocol type carried in ARP
  localparam mac_addr_t   MAC_BROADCAST  = '1;

endpackage : eth_pkg

`default_nettype wire

// ==== common/arp_pkg.sv ====
`default_nettype none

package arp_pkg;

  import eth_pkg::*;

  typedef enum logic [15:0] {
    arp_request = 16'd1,
    arp_reply   = 16'd2
  } arp_oper_e;

  // Fields in wire order, first byte in the top bits
  typedef struct packed {
    logic [15:0] hw_type;
    logic [15:0] proto;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    arp_oper_e   oper;
    mac_addr_t   src_mac;
    ipv4_t       src_ipv4;
    mac_addr_t   dst_mac;
    ipv4_t       dst_ipv4;
  } arp_hdr_t;

  typedef struct packed {
    ipv4_t     ipv4;
    mac_addr_t mac;
  } arp_entry_t;

  localparam int          ARP_HDR_BYTES     = 28;
  localparam int          HDR_CNT_W         = $clog2(ARP_HDR_BYTES + 1);
  localparam logic [15:0] HW_TYPE_ETH       = 16'd1;
  localparam logic [7:0]  ARP_HLEN          = 8'd6;
  localparam logic [7:0]  ARP_PLEN          = 8'd4;
  localparam int          TABLE_AW          = 2;
  localparam int          TABLE_DEPTH       = 1 << TABLE_AW;
  localparam int          ARP_TIMEOUT_TICKS = 300;
  localparam int          TIMEOUT_W         = $clog2(ARP_TIMEOUT_TICKS);

endpackage : arp_pkg

`default_nettype wire

// ==== arp/arp_rx_parse.sv ====
`timescale 1ns/1ps
`default_nettype none

module arp_rx_parse
  import eth_pkg::*, arp_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire dev_t        dev,
  input  wire [7:0]        rx_data,
  input  wire              rx_val,
  input  wire              rx_sof,
  output logic             learn_val,
  output arp_entry_t       learn,
  output logic             reply_val,
  output arp_entry_t       reply_to
);

  arp_hdr_t             hdr_sr;
  arp_hdr_t             hdr_nxt;
  logic [HDR_CNT_W-1:0] byte_cnt;
  logic                 counting;
  logic                 last_byte;
  logic                 hdr_ok;
  logic                 for_us;

  assign hdr_nxt = {hdr_sr[$bits(arp_hdr_t)-9:0], rx_data}; // MSB first

  // Zero waits for a start, full count waits for the next one
  assign counting  = byte_cnt != '0 && byte_cnt != HDR_CNT_W'(ARP_HDR_BYTES);
  assign last_byte = rx_val && !rx_sof && byte_cnt == HDR_CNT_W'(ARP_HDR_BYTES - 1);

  assign hdr_ok = hdr_nxt.hw_type == HW_TYPE_ETH &&
                  hdr_nxt.proto   == ETHERTYPE_IPV4 &&
                  hdr_nxt.hlen    == ARP_HLEN &&
                  hdr_nxt.plen    == ARP_PLEN;

  assign for_us = hdr_nxt.oper == arp_request && hdr_nxt.dst_ipv4 == dev.ipv4_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt  <= '0;
      learn_val <= 1'b0;
      reply_val <= 1'b0;
    end else begin
      learn_val <= last_byte && hdr_ok;
      reply_val <= last_byte && hdr_ok && for_us;
      if (rx_val) begin
        if (rx_sof) begin
          byte_cnt <= HDR_CNT_W'(1); // Restart on any new payload
        end else if (counting) begin
          byte_cnt <= byte_cnt + HDR_CNT_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_val) hdr_sr <= hdr_nxt;
    if (last_byte) learn <= '{ipv4: hdr_nxt.src_ipv4, mac: hdr_nxt.src_mac};
  end

  assign reply_to = learn; // The asker is the sender

  a_reply_needs_learn : assert property (
    @(posedge clk) disable iff (rst) reply_val |-> learn_val
  );

endmodule : arp_rx_parse

`default_nettype wire

// ==== arp/arp_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module arp_table
  import eth_pkg::*, arp_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire dev_t        dev,
  input  wire              learn_val,
  input  wire arp_entry_t  learn,
  input  wire              lookup_req,
  input  wire ipv4_t       lookup_ipv4,
  output logic             lookup_done,
  output mac_addr_t        lookup_mac,
  output logic             lookup_err,
  output arp_hdr_t         req_hdr,
  output logic             send_req,
  input  wire              tx_busy
);

  typedef enum logic [1:0] {
    learn_idle,
    learn_scan,
    learn_upd,
    learn_add
  } learn_st_e;

  typedef enum logic [1:0] {
    look_idle,
    look_scan,
    look_send,
    look_wait
  } look_st_e;

  arp_entry_t           entry [TABLE_DEPTH];
  logic [TABLE_DEPTH-1:0] ent_val;

  learn_st_e            learn_st;
  arp_entry_t           cur_ent;
  logic [TABLE_AW-1:0]  l_idx;
  logic [TABLE_AW-1:0]  rr_ptr;
  logic                 l_hit;
  logic                 wr_en;
  logic [TABLE_AW-1:0]  wr_idx;

  look_st_e             look_st;
  ipv4_t                look_ip;
  logic [TABLE_AW-1:0]  k_idx;
  logic                 k_hit;
  logic [TIMEOUT_W-1:0] tmr;

  assign l_hit  = ent_val[l_idx] && entry[l_idx].ipv4 == cur_ent.ipv4;
  assign wr_en  = learn_st == learn_upd || learn_st == learn_add;
  assign wr_idx = (learn_st == learn_upd) ? l_idx : rr_ptr;

  // Learn machine, one entry compared per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      learn_st <= learn_idle;
      l_idx    <= '0;
      rr_ptr   <= '0;
      ent_val  <= '0;
    end else begin
      case (learn_st)
        learn_idle: begin
          l_idx <= '0;
          if (learn_val) begin
            cur_ent  <= learn;
            learn_st <= learn_scan;
          end
        end
        learn_scan: begin
          if (l_hit) begin
            learn_st <= learn_upd; // l_idx keeps the matching slot
          end else if (l_idx == '1) begin
            learn_st <= learn_add;
          end else begin
            l_idx <= l_idx + TABLE_AW'(1);
          end
        end
        learn_upd: begin
          ent_val[wr_idx] <= 1'b1;
          learn_st        <= learn_idle;
        end
        learn_add: begin
          ent_val[wr_idx] <= 1'b1;
          rr_ptr          <= rr_ptr + TABLE_AW'(1);
          learn_st        <= learn_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) entry[wr_idx] <= cur_ent;
  end

  assign k_hit    = ent_val[k_idx] && entry[k_idx].ipv4 == look_ip;
  assign send_req = look_st == look_send && !tx_busy;

  // Lookup machine
  always_ff @(posedge clk) begin
    if (rst) begin
      look_st     <= look_idle;
      k_idx       <= '0;
      tmr         <= '0;
      lookup_done <= 1'b0;
      lookup_err  <= 1'b0;
    end else begin
      lookup_done <= 1'b0;
      lookup_err  <= 1'b0;
      case (look_st)
        look_idle: begin
          k_idx <= '0;
          if (lookup_req) begin
            look_ip <= lookup_ipv4;
            look_st <= look_scan;
          end
        end
        look_scan: begin
          k_idx <= k_idx + TABLE_AW'(1);
          if (k_hit) begin
            lookup_mac  <= entry[k_idx].mac;
            lookup_done <= 1'b1;
            look_st     <= look_idle;
          end else if (k_idx == '1) begin
            req_hdr <= '{hw_type: HW_TYPE_ETH, proto: ETHERTYPE_IPV4,
                         hlen: ARP_HLEN, plen: ARP_PLEN, oper: arp_request,
                         src_mac: dev.mac_addr, src_ipv4: dev.ipv4_addr,
                         dst_mac: '0, dst_ipv4: look_ip};
            look_st <= look_send;
          end
        end
        look_send: begin
          tmr <= '0;
          if (!tx_busy) look_st <= look_wait;
        end
        look_wait: begin
          tmr <= tmr + TIMEOUT_W'(1);
          if (learn_val && learn.ipv4 == look_ip) begin
            lookup_mac  <= learn.mac; // Reply seen on the learn path
            lookup_done <= 1'b1;
            look_st     <= look_idle;
          end else if (tmr == TIMEOUT_W'(ARP_TIMEOUT_TICKS - 1)) begin
            lookup_err <= 1'b1;
            look_st    <= look_idle;
          end
        end
      endcase
    end
  end

  a_done_err_excl : assert property (
    @(posedge clk) disable iff (rst) !(lookup_done && lookup_err)
  );

  // Transmitter must take the request in the same cycle
  a_send_taken : assert property (
    @(posedge clk) disable iff (rst) send_req |-> !tx_busy ##1 tx_busy
  );

endmodule : arp_table

`default_nettype wire

// ==== arp/arp_tx_build.sv ====
`timescale 1ns/1ps
`default_nettype none

module arp_tx_build
  import eth_pkg::*, arp_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire dev_t        dev,
  input  wire              send_req,
  input  wire arp_hdr_t    req_hdr,
  input  wire              reply_val,
  input  wire arp_entry_t  reply_to,
  output logic             tx_busy,
  output logic [7:0]       tx_data,
  output logic             tx_val,
  output logic             tx_sof,
  output logic             tx_eof
);

  typedef enum logic [1:0] {
    tx_idle,
    tx_send,
    tx_tail
  } tx_st_e;

  tx_st_e               tx_st;
  logic [HDR_CNT_W-1:0] tx_cnt;
  arp_hdr_t             sh_hdr;
  arp_hdr_t             reply_hdr;
  arp_entry_t           pend_to;
  logic                 pend_val;
  logic                 pend_load;
  logic                 take_req;
  logic                 take_pend;
  logic                 last_cnt;

  assign take_req  = tx_st == tx_idle && send_req; // Table request wins
  assign take_pend = tx_st == tx_idle && !send_req && pend_val;
  assign pend_load = reply_val && (!pend_val || take_pend); // One deep, extra dropped
  assign last_cnt  = tx_cnt == HDR_CNT_W'(ARP_HDR_BYTES - 1);

  assign reply_hdr = '{hw_type: HW_TYPE_ETH, proto: ETHERTYPE_IPV4,
                       hlen: ARP_HLEN, plen: ARP_PLEN, oper: arp_reply,
                       src_mac: dev.mac_addr, src_ipv4: dev.ipv4_addr,
                       dst_mac: pend_to.mac, dst_ipv4: pend_to.ipv4};

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_st    <= tx_idle;
      tx_cnt   <= '0;
      pend_val <= 1'b0;
    end else begin
      if (take_pend) pend_val <= 1'b0;
      if (pend_load) pend_val <= 1'b1;
      case (tx_st)
        tx_idle: begin
          tx_cnt <= '0;
          if (take_req || take_pend) tx_st <= tx_send;
        end
        tx_send: begin
          tx_cnt <= tx_cnt + HDR_CNT_W'(1);
          if (last_cnt) tx_st <= tx_tail;
        end
        tx_tail: tx_st <= tx_idle; // Gap cycle after the last byte
        default: tx_st <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pend_load) pend_to <= reply_to;
    if (take_req) begin
      sh_hdr <= req_hdr;
    end else if (take_pend) begin
      sh_hdr <= reply_hdr;
    end else if (tx_st == tx_send) begin
      sh_hdr <= {sh_hdr[$bits(arp_hdr_t)-9:0], 8'h00};
    end
  end

  assign tx_data = sh_hdr[$bits(arp_hdr_t)-1 -: 8];
  assign tx_val  = tx_st == tx_send;
  assign tx_sof  = tx_val && tx_cnt == '0;
  assign tx_eof  = tx_val && last_cnt;
  assign tx_busy = tx_st != tx_idle || pend_val;

  a_marks_in_frame : assert property (
    @(posedge clk) disable iff (rst) (tx_sof || tx_eof) |-> tx_val
  );

endmodule : arp_tx_build

`default_nettype wire

// ==== arp/arp_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arp_top
  import eth_pkg::*, arp_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire dev_t        dev,
  input  wire [7:0]        rx_data,
  input  wire              rx_val,
  input  wire              rx_sof,
  input  wire              lookup_req,
  input  wire ipv4_t       lookup_ipv4,
  output logic             lookup_done,
  output mac_addr_t        lookup_mac,
  output logic             lookup_err,
  output logic [7:0]       tx_data,
  output logic             tx_val,
  output logic             tx_sof,
  output logic             tx_eof
);

  logic       learn_val;
  arp_entry_t learn;
  logic       reply_val;
  arp_entry_t reply_to;
  logic       send_req;
  arp_hdr_t   req_hdr;
  logic       tx_busy;

  arp_rx_parse parse_i (
    .clk       (clk),
    .rst       (rst),
    .dev       (dev),
    .rx_data   (rx_data),
    .rx_val    (rx_val),
    .rx_sof    (rx_sof),
    .learn_val (learn_val),
    .learn     (learn),
    .reply_val (reply_val),
    .reply_to  (reply_to)
  );

  arp_table table_i (
    .clk         (clk),
    .rst         (rst),
    .dev         (dev),
    .learn_val   (learn_val),
    .learn       (learn),
    .lookup_req  (lookup_req),
    .lookup_ipv4 (lookup_ipv4),
    .lookup_done (lookup_done),
    .lookup_mac  (lookup_mac),
    .lookup_err  (lookup_err),
    .req_hdr     (req_hdr),
    .send_req    (send_req),
    .tx_busy     (tx_busy)
  );

  arp_tx_build tx_i (
    .clk       (clk),
    .rst       (rst),
    .dev       (dev),
    .send_req  (send_req),
    .req_hdr   (req_hdr),
    .reply_val (reply_val),
    .reply_to  (reply_to),
    .tx_busy   (tx_busy),
    .tx_data   (tx_data),
    .tx_val    (tx_val),
    .tx_sof    (tx_sof),
    .tx_eof    (tx_eof)
  );

endmodule : arp_top

`default_nettype wire

// ==== dv/arp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module arp_tb
  import eth_pkg::*, arp_pkg::*;
();

  localparam logic [31:0] SEED        = 32'h34e1_4f12;
  localparam int          PKT_GAP     = 12;
  localparam int          FRAME_LIMIT = 2 * ARP_HDR_BYTES + 16;
  localparam int          RESULT_LIMIT = ARP_TIMEOUT_TICKS + 4 * ARP_HDR_BYTES;
  localparam int          NUM_LOOKUPS = 22;
  localparam int          NUM_PKTS    = 19;
  localparam int          WATCHDOG_CYCLES = NUM_LOOKUPS * (RESULT_LIMIT + 8) +
                                            NUM_PKTS * (ARP_HDR_BYTES + PKT_GAP + FRAME_LIMIT) +
                                            1000;

  logic       clk;
  logic       rst;
  dev_t       dev;
  logic [7:0] rx_data;
  logic       rx_val;
  logic       rx_sof;
  logic       lookup_req;
  ipv4_t      lookup_ipv4;
  logic       lookup_done;
  mac_addr_t  lookup_mac;
  logic       lookup_err;
  logic [7:0] tx_data;
  logic       tx_val;
  logic       tx_sof;
  logic       tx_eof;

  // Reference table
  ipv4_t      m_ip  [TABLE_DEPTH];
  mac_addr_t  m_mac [TABLE_DEPTH];
  bit         m_val [TABLE_DEPTH];
  int         m_rr;

  int         errors = 0;
  int         tests_ok = 0;
  int         tests_bad = 0;
  int         done_cnt = 0;
  int         err_cnt = 0;
  mac_addr_t  done_mac;
  arp_hdr_t   frame_cur;
  int         frame_bytes = 0;
  arp_hdr_t   frames [$]; // Completed tx payloads

  arp_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .dev         (dev),
    .rx_data     (rx_data),
    .rx_val      (rx_val),
    .rx_sof      (rx_sof),
    .lookup_req  (lookup_req),
    .lookup_ipv4 (lookup_ipv4),
    .lookup_done (lookup_done),
    .lookup_mac  (lookup_mac),
    .lookup_err  (lookup_err),
    .tx_data     (tx_data),
    .tx_val      (tx_val),
    .tx_sof      (tx_sof),
    .tx_eof      (tx_eof)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic note_fail(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic compare_int(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("CHECK FAILED %s: got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_vec(input string name, input logic [223:0] got,
                             input logic [223:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic ipv4_t rand_ip();
    rand_ip = {8'd10, 24'($urandom)};
  endfunction

  function automatic ipv4_t rand_unknown();
    rand_unknown = {8'd172, 8'd16, 16'($urandom)}; // Never used by learned senders
  endfunction

  function automatic mac_addr_t rand_mac();
    rand_mac = {8'h02, 8'($urandom), $urandom};
  endfunction

  function automatic arp_hdr_t make_hdr(input arp_oper_e op, input mac_addr_t smac,
                                        input ipv4_t sip, input mac_addr_t dmac,
                                        input ipv4_t dip);
    arp_hdr_t h;
    h.hw_type  = 16'd1;
    h.proto    = 16'h0800;
    h.hlen     = 8'd6;
    h.plen     = 8'd4;
    h.oper     = op;
    h.src_mac  = smac;
    h.src_ipv4 = sip;
    h.dst_mac  = dmac;
    h.dst_ipv4 = dip;
    return h;
  endfunction

  function automatic int model_find(input ipv4_t ip);
    int slot;
    slot = -1;
    for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
      if (m_val[i] && m_ip[i] == ip) slot = i; // Lowest match wins, as in a forward scan
    end
    return slot;
  endfunction

  task automatic model_learn(input ipv4_t ip, input mac_addr_t mac);
    int slot;
    slot = model_find(ip);
    if (slot < 0) begin
      slot = m_rr;
      m_rr = (m_rr + 1) % TABLE_DEPTH;
    end
    m_ip[slot]  = ip;
    m_mac[slot] = mac;
    m_val[slot] = 1'b1;
  endtask

  task automatic send_pkt(input arp_hdr_t h);
    for (int i = 0; i < ARP_HDR_BYTES; i++) begin
      @(posedge clk);
      rx_val  <= 1'b1;
      rx_sof  <= (i == 0);
      rx_data <= h[$bits(arp_hdr_t) - 1 - 8 * i -: 8];
    end
    @(posedge clk);
    rx_val <= 1'b0;
    rx_sof <= 1'b0;
    repeat (PKT_GAP) @(posedge clk);
  endtask

  task automatic start_lookup(input ipv4_t ip);
    @(posedge clk);
    lookup_req  <= 1'b1;
    lookup_ipv4 <= ip;
    @(posedge clk);
    lookup_req  <= 1'b0;
  endtask

  task automatic wait_result(input int d0, input int e0);
    int n;
    n = 0;
    while (done_cnt == d0 && err_cnt == e0 && n < RESULT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (done_cnt == d0 && err_cnt == e0) note_fail("Lookup ended with neither done nor error");
  endtask

  task automatic wait_frame();
    int n;
    n = 0;
    while (frames.size() == 0 && n < FRAME_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (frames.size() == 0) note_fail("Expected tx frame did not arrive");
  endtask

  // Lookup checked against the model, a miss must broadcast a request and time out
  task automatic run_lookup(input ipv4_t ip);
    int slot;
    int d0;
    int e0;
    slot = model_find(ip);
    @(negedge clk);
    frames.delete();
    d0 = done_cnt;
    e0 = err_cnt;
    start_lookup(ip);
    wait_result(d0, e0);
    if (slot >= 0) begin
      compare_int("lookup_done", done_cnt - d0, 1);
      compare_int("lookup_err", err_cnt - e0, 0);
      compare_vec("lookup_mac", 224'(done_mac), 224'(m_mac[slot]));
      compare_int("tx frame count", frames.size(), 0);
    end else begin
      compare_int("lookup_err", err_cnt - e0, 1);
      compare_int("lookup_done", done_cnt - d0, 0);
      compare_int("tx frame count", frames.size(), 1);
      if (frames.size() > 0) begin
        compare_vec("request frame", frames.pop_front(),
                    make_hdr(arp_request, dev.mac_addr, dev.ipv4_addr, '0, ip));
      end
    end
  endtask

  task automatic end_test(input string name, input int err0);
    if (errors == err0) begin
      tests_ok++;
      $display("Test %0s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %0s: %0d errors", name, errors - err0);
    end
  endtask

  always @(posedge clk) begin
    if (lookup_done) begin
      done_cnt <= done_cnt + 1;
      done_mac <= lookup_mac;
    end
    if (lookup_err) err_cnt <= err_cnt + 1;
    if (tx_val) begin
      if (tx_sof) frame_bytes = 0;
      frame_cur = {frame_cur[$bits(arp_hdr_t) - 9:0], tx_data};
      frame_bytes++;
      if (tx_eof) begin
        compare_int("tx frame length", frame_bytes, ARP_HDR_BYTES);
        frames.push_back(frame_cur);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    ipv4_t     ip;
    mac_addr_t mac;
    arp_hdr_t  h;
    ipv4_t     known [$];
    int        err0;
    int        d0;
    int        e0;
    void'($urandom(SEED));
    rst           = 1'b1;
    rx_data       = '0;
    rx_val        = 1'b0;
    rx_sof        = 1'b0;
    lookup_req    = 1'b0;
    lookup_ipv4   = '0;
    dev.mac_addr  = 48'h02aa_bbcc_ddee;
    dev.ipv4_addr = 32'hc0a8_0101;
    m_rr          = 0;
    for (int i = 0; i < TABLE_DEPTH; i++) m_val[i] = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    err0 = errors;
    for (int i = 0; i < TABLE_DEPTH; i++) begin
      ip  = rand_ip();
      mac = rand_mac();
      send_pkt(make_hdr(arp_reply, mac, ip, dev.mac_addr, dev.ipv4_addr));
      model_learn(ip, mac);
      known.push_back(ip);
    end
    foreach (known[i]) run_lookup(known[i]);
    end_test("learn and hit", err0);

    err0 = errors;
    for (int i = 0; i < TABLE_DEPTH + 2; i++) begin
      ip  = rand_ip();
      mac = rand_mac();
      send_pkt(make_hdr(arp_reply, mac, ip, dev.mac_addr, dev.ipv4_addr));
      model_learn(ip, mac);
      known.push_back(ip);
    end
    for (int i = 0; i < TABLE_DEPTH; i += 2) begin
      ip  = m_ip[i]; // Retained sender with a new MAC
      mac = rand_mac();
      send_pkt(make_hdr(arp_reply, mac, ip, dev.mac_addr, dev.ipv4_addr));
      model_learn(ip, mac);
    end
    foreach (known[i]) run_lookup(known[i]);
    end_test("update and eviction", err0);

    err0 = errors;
    ip = rand_unknown();
    @(negedge clk);
    frames.delete();
    d0 = done_cnt;
    e0 = err_cnt;
    start_lookup(ip);
    wait_frame();
    if (frames.size() > 0) begin
      compare_vec("request frame", frames.pop_front(),
                  make_hdr(arp_request, dev.mac_addr, dev.ipv4_addr, '0, ip));
    end
    mac = rand_mac();
    send_pkt(make_hdr(arp_reply, mac, ip, dev.mac_addr, dev.ipv4_addr));
    model_learn(ip, mac);
    wait_result(d0, e0);
    compare_int("lookup_done", done_cnt - d0, 1);
    compare_int("lookup_err", err_cnt - e0, 0);
    compare_vec("lookup_mac", 224'(done_mac), 224'(mac));
    end_test("miss with reply", err0);

    err0 = errors;
    run_lookup(rand_unknown());
    end_test("timeout", err0);

    err0 = errors;
    ip  = rand_ip();
    mac = rand_mac();
    @(negedge clk);
    frames.delete();
    send_pkt(make_hdr(arp_request, mac, ip, '0, dev.ipv4_addr));
    model_learn(ip, mac);
    wait_frame();
    if (frames.size() > 0) begin
      compare_vec("reply frame", frames.pop_front(),
                  make_hdr(arp_reply, dev.mac_addr, dev.ipv4_addr, mac, ip));
    end
    run_lookup(ip);
    ip  = rand_ip();
    mac = rand_mac();
    @(negedge clk);
    frames.delete();
    send_pkt(make_hdr(arp_request, mac, ip, '0, dev.ipv4_addr + 32'd1));
    repeat (FRAME_LIMIT) @(negedge clk);
    compare_int("tx frame count", frames.size(), 0);
    model_learn(ip, mac);
    run_lookup(ip);
    end_test("answering requests", err0);

    err0 = errors;
    for (int k = 0; k < 4; k++) begin
      ip = rand_unknown();
      h  = make_hdr(arp_request, rand_mac(), ip, '0, dev.ipv4_addr);
      case (k)
        0: h.hw_type = 16'd6;
        1: h.proto   = 16'h86dd;
        2: h.hlen    = 8'd8;
        default: h.plen = 8'd16;
      endcase
      @(negedge clk);
      frames.delete();
      send_pkt(h);
      repeat (FRAME_LIMIT) @(negedge clk);
      compare_int("tx frame count", frames.size(), 0);
      run_lookup(ip); // Not learned, so a miss
    end
    end_test("malformed packets", err0);

    $display("Tests ok: %0d, tests failing: %0d, check errors: %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : arp_tb

`default_nettype wire

// ==== verilog.f ====
common/eth_pkg.sv
common/arp_pkg.sv
arp/arp_rx_parse.sv
arp/arp_table.sv
arp/arp_tx_build.sv
arp/arp_top.sv
dv/arp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ARP engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
  --top-module arp_tb -f verilog.f -o arp_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit 1
fi

./obj_dir/arp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "No pass line found in sim.log"
  exit 1
fi
exit 0
